/* verilog/rvCore_config.svh */
// RV32I core configuration
`ifndef RvCoreConfigSvh
`define RvCoreConfigSvh

// data and address width
`define XLen 32

// first fetch address after reset
`define ResetPc 32'h00000000

// addi x0, x0, 0
`define NopInst 32'h00000013

// integer register count, x0 included
`define RegCount 32

`endif

/* verilog/rvCorePkg.sv */
// RV32I core shared types
`default_nettype none

`include "rvCore_config.svh"

package rvCorePkg;

  // blt and bltu reuse slt and sltu, result sits in bit 0
  typedef enum logic [3:0] {
    AluAdd,
    AluSub,
    AluSll,
    AluSlt,
    AluSltu,
    AluXor,
    AluSrl,
    AluSra,
    AluOr,
    AluAnd,
    AluPassB,
    AluEq,
    AluNe,
    AluGe,
    AluGeu
  } aluOpT;

  // encoding matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    MemByte = 2'd0,
    MemHalf = 2'd1,
    MemWord = 2'd2
  } memWidthT;

  typedef struct packed {
    aluOpT aluOp;
    memWidthT memWidth;
    logic loadUnsigned;
    logic regWen;
    logic memRen;
    logic memWen;
    logic useImm;
    logic usePcA;
    logic isBranch;
    logic isJump;
    logic isJalr;
    logic isEbreak;
    logic illegal;
    logic valid;
  } ctrlT;

  typedef struct packed {
    logic [`XLen-1:0] pc;
    logic [31:0] inst;
  } ifIdT;

  typedef struct packed {
    logic [`XLen-1:0] pc;
    ctrlT ctrl;
    logic [`XLen-1:0] imm;
    logic [`XLen-1:0] rs1Data;
    logic [`XLen-1:0] rs2Data;
    logic [4:0] rd;
  } idExT;

endpackage

`default_nettype wire

/* verilog/pipeStage.sv */
// Pipeline register
`timescale 1ns/1ps
`default_nettype none

module pipeStage #(
  parameter type payloadT = logic,
  parameter payloadT bubble = '0
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    flush,
  input  logic    enable,
  input  payloadT din,
  output payloadT dout
);

  // flush wins over enable so a killed slot never holds stale work
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      dout <= bubble;
    end else if (enable) begin
      dout <= din;
    end
  end

endmodule

`default_nettype wire

/* verilog/rvDecoder.sv */
// RV32I instruction decoder
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_config.svh"

module rvDecoder (
  input  logic [31:0]         inst,
  input  logic                instValid,
  output logic [4:0]          rs1,
  output logic [4:0]          rs2,
  output logic [4:0]          rd,
  output logic [`XLen-1:0]    imm,
  output rvCorePkg::ctrlT     ctrl
);

  localparam logic [6:0] OpLui    = 7'b0110111;
  localparam logic [6:0] OpAuipc  = 7'b0010111;
  localparam logic [6:0] OpJal    = 7'b1101111;
  localparam logic [6:0] OpJalr   = 7'b1100111;
  localparam logic [6:0] OpBranch = 7'b1100011;
  localparam logic [6:0] OpLoad   = 7'b0000011;
  localparam logic [6:0] OpStore  = 7'b0100011;
  localparam logic [6:0] OpImm    = 7'b0010011;
  localparam logic [6:0] OpReg    = 7'b0110011;
  localparam logic [31:0] Ebreak  = 32'h00100073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [`XLen-1:0] immI;
  logic [`XLen-1:0] immS;
  logic [`XLen-1:0] immB;
  logic [`XLen-1:0] immU;
  logic [`XLen-1:0] immJ;
  logic legal;

  // shared by register-immediate and register-register ops
  function automatic rvCorePkg::aluOpT opFromFunct3(input logic [2:0] f3, input logic alt);
    rvCorePkg::aluOpT op;
    case (f3)
      3'b000: op = alt ? rvCorePkg::AluSub : rvCorePkg::AluAdd;
      3'b001: op = rvCorePkg::AluSll;
      3'b010: op = rvCorePkg::AluSlt;
      3'b011: op = rvCorePkg::AluSltu;
      3'b100: op = rvCorePkg::AluXor;
      3'b101: op = alt ? rvCorePkg::AluSra : rvCorePkg::AluSrl;
      3'b110: op = rvCorePkg::AluOr;
      default: op = rvCorePkg::AluAnd;
    endcase
    return op;
  endfunction

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl = '0;
    imm = immI;
    legal = 1'b1;
    case (opcode)
      OpLui: begin
        ctrl.aluOp = rvCorePkg::AluPassB;
        ctrl.useImm = 1'b1;
        ctrl.regWen = 1'b1;
        imm = immU;
      end
      OpAuipc: begin
        ctrl.usePcA = 1'b1;
        ctrl.useImm = 1'b1;
        ctrl.regWen = 1'b1;
        imm = immU;
      end
      OpJal: begin
        ctrl.usePcA = 1'b1;
        ctrl.useImm = 1'b1;
        ctrl.isJump = 1'b1;
        ctrl.regWen = 1'b1;
        imm = immJ;
      end
      OpJalr: begin
        ctrl.useImm = 1'b1;
        ctrl.isJump = 1'b1;
        ctrl.isJalr = 1'b1;
        ctrl.regWen = 1'b1;
        legal = (funct3 == 3'b000);
      end
      OpBranch: begin
        ctrl.isBranch = 1'b1;
        imm = immB;
        legal = (funct3[2:1] != 2'b01);
        case (funct3)
          3'b000: ctrl.aluOp = rvCorePkg::AluEq;
          3'b001: ctrl.aluOp = rvCorePkg::AluNe;
          3'b100: ctrl.aluOp = rvCorePkg::AluSlt;
          3'b101: ctrl.aluOp = rvCorePkg::AluGe;
          3'b110: ctrl.aluOp = rvCorePkg::AluSltu;
          default: ctrl.aluOp = rvCorePkg::AluGeu;
        endcase
      end
      OpLoad: begin
        ctrl.useImm = 1'b1;
        ctrl.memRen = 1'b1;
        ctrl.regWen = 1'b1;
        ctrl.memWidth = rvCorePkg::memWidthT'(funct3[1:0]);
        ctrl.loadUnsigned = funct3[2];
        // lb lh lw lbu lhu only
        legal = (funct3[1:0] != 2'b11) && !(funct3[2] && funct3[1]);
      end
      OpStore: begin
        ctrl.useImm = 1'b1;
        ctrl.memWen = 1'b1;
        ctrl.memWidth = rvCorePkg::memWidthT'(funct3[1:0]);
        imm = immS;
        legal = !funct3[2] && (funct3[1:0] != 2'b11);
      end
      OpImm: begin
        ctrl.useImm = 1'b1;
        ctrl.regWen = 1'b1;
        ctrl.aluOp = opFromFunct3(funct3, (funct3 == 3'b101) && funct7[5]);
        if (funct3 == 3'b001) begin
          legal = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end
      end
      OpReg: begin
        ctrl.regWen = 1'b1;
        ctrl.aluOp = opFromFunct3(funct3, funct7[5]);
        // funct7 bit 5 only for sub and sra
        legal = (funct7 == 7'b0000000) ||
                ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      end
      default: begin
        ctrl.isEbreak = (inst == Ebreak);
        legal = (inst == Ebreak);
      end
    endcase

    if (!legal) begin
      ctrl = '0;
      ctrl.illegal = 1'b1;
    end

    if (instValid) begin
      ctrl.valid = 1'b1;
    end else begin
      ctrl = '0;
    end

    // rd reads as zero for anything that leaves the register file alone
    rd = ctrl.regWen ? inst[11:7] : 5'd0;
  end

endmodule

`default_nettype wire

/* verilog/regFile.sv */
// Integer register file
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_config.svh"

module regFile (
  input  logic                          clk,
  input  logic [$clog2(`RegCount)-1:0]  rs1,
  input  logic [$clog2(`RegCount)-1:0]  rs2,
  input  logic [$clog2(`RegCount)-1:0]  rd,
  input  logic                          wen,
  input  logic [`XLen-1:0]              wdata,
  output logic [`XLen-1:0]              rs1Data,
  output logic [`XLen-1:0]              rs2Data
);

  logic [`XLen-1:0] regs [`RegCount];

  // x0 slot is never written
  always_ff @(posedge clk) begin
    if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // reads are combinational, same-cycle writes reach ID through forwarding
  assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* verilog/rvAlu.sv */
// Integer ALU
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_config.svh"

module rvAlu (
  input  logic [`XLen-1:0]  opA,
  input  logic [`XLen-1:0]  opB,
  input  rvCorePkg::aluOpT  aluOp,
  output logic [`XLen-1:0]  result
);

  logic [4:0] shamt;
  logic lessSigned;
  logic lessUnsigned;

  assign shamt = opB[4:0];
  assign lessSigned = $signed(opA) < $signed(opB);
  assign lessUnsigned = opA < opB;

  // compares leave their flag in bit 0
  always_comb begin
    case (aluOp)
      rvCorePkg::AluAdd:   result = opA + opB;
      rvCorePkg::AluSub:   result = opA - opB;
      rvCorePkg::AluSll:   result = opA << shamt;
      rvCorePkg::AluSlt:   result = {{(`XLen-1){1'b0}}, lessSigned};
      rvCorePkg::AluSltu:  result = {{(`XLen-1){1'b0}}, lessUnsigned};
      rvCorePkg::AluXor:   result = opA ^ opB;
      rvCorePkg::AluSrl:   result = opA >> shamt;
      rvCorePkg::AluSra:   result = $unsigned($signed(opA) >>> shamt);
      rvCorePkg::AluOr:    result = opA | opB;
      rvCorePkg::AluAnd:   result = opA & opB;
      rvCorePkg::AluPassB: result = opB;
      rvCorePkg::AluEq:    result = {{(`XLen-1){1'b0}}, opA == opB};
      rvCorePkg::AluNe:    result = {{(`XLen-1){1'b0}}, opA != opB};
      rvCorePkg::AluGe:    result = {{(`XLen-1){1'b0}}, !lessSigned};
      rvCorePkg::AluGeu:   result = {{(`XLen-1){1'b0}}, !lessUnsigned};
      default:             result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/loadStoreUnit.sv */
// Load and store byte lane alignment
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_config.svh"

module loadStoreUnit (
  input  logic [`XLen-1:0]    addr,
  input  logic [`XLen-1:0]    storeData,
  input  logic [`XLen-1:0]    rdataWord,
  input  rvCorePkg::memWidthT memWidth,
  input  logic                loadUnsigned,
  output logic [3:0]          strb,
  output logic [`XLen-1:0]    wdataWord,
  output logic [`XLen-1:0]    loadData
);

  logic [1:0] offset;
  logic [`XLen-1:0] shifted;

  // only the byte offset matters here, the word address goes straight out
  assign offset = addr[1:0];

  // store side, data copied into every lane so the strobe picks the right one
  always_comb begin
    case (memWidth)
      rvCorePkg::MemByte: begin
        wdataWord = {4{storeData[7:0]}};
        strb = 4'b0001 << offset;
      end
      rvCorePkg::MemHalf: begin
        wdataWord = {2{storeData[15:0]}};
        strb = 4'b0011 << {offset[1], 1'b0};
      end
      default: begin
        wdataWord = storeData;
        strb = 4'b1111;
      end
    endcase
  end

  // addressed lane moved down to bit 0
  assign shifted = rdataWord >> {offset, 3'b000};

  always_comb begin
    case (memWidth)
      rvCorePkg::MemByte: begin
        loadData = {{24{!loadUnsigned && shifted[7]}}, shifted[7:0]};
      end
      rvCorePkg::MemHalf: begin
        loadData = {{16{!loadUnsigned && shifted[15]}}, shifted[15:0]};
      end
      default: begin
        loadData = rdataWord;
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/rvCore.sv */
// Three-stage RV32I core
`timescale 1ns/1ps
`default_nettype none

`include "rvCore_config.svh"

module rvCore (
  input  logic              clk,
  input  logic              rst,
  output logic [`XLen-1:0]  instAddr,
  input  logic [31:0]       instData,
  output logic [`XLen-1:0]  dataAddr,
  output logic [`XLen-1:0]  dataWdata,
  output logic [3:0]        dataStrb,
  output logic              dataWen,
  output logic              dataRen,
  input  logic [`XLen-1:0]  dataRdata,
  output logic              retireValid,
  output logic [`XLen-1:0]  retirePc,
  output logic [4:0]        retireRd,
  output logic [`XLen-1:0]  retireData,
  output logic              halted,
  output logic              trapIllegal
);

  localparam logic [`XLen-1:0] InstBytes = 4;
  localparam rvCorePkg::ifIdT IfIdBubble = '{pc: `ResetPc, inst: `NopInst};
  localparam rvCorePkg::idExT IdExBubble = '0;

  logic [`XLen-1:0] pc;
  logic idValid;
  rvCorePkg::ifIdT ifIdIn;
  rvCorePkg::ifIdT ifIdQ;
  rvCorePkg::idExT idExIn;
  rvCorePkg::idExT idExQ;

  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [4:0] rdId;
  logic [`XLen-1:0] immId;
  rvCorePkg::ctrlT ctrlId;
  logic [`XLen-1:0] rs1Raw;
  logic [`XLen-1:0] rs2Raw;
  logic fwdA;
  logic fwdB;

  logic exValid;
  logic [`XLen-1:0] opA;
  logic [`XLen-1:0] opB;
  logic [`XLen-1:0] aluResult;
  logic [`XLen-1:0] loadData;
  logic [`XLen-1:0] wbData;
  logic [`XLen-1:0] linkPc;
  logic [`XLen-1:0] transferTarget;
  logic taken;
  logic stopEx;
  logic flush;

  // fetch
  assign instAddr = pc;
  assign ifIdIn.pc = pc;
  assign ifIdIn.inst = instData;

  pipeStage #(.payloadT(rvCorePkg::ifIdT), .bubble(IfIdBubble)) ifIdStage (
    .clk    (clk),
    .rst    (rst),
    .flush  (flush),
    .enable (!halted),
    .din    (ifIdIn),
    .dout   (ifIdQ)
  );

  // decode and register read
  rvDecoder decoder0 (
    .inst      (ifIdQ.inst),
    .instValid (idValid),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rdId),
    .imm       (immId),
    .ctrl      (ctrlId)
  );

  regFile regFile0 (
    .clk     (clk),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (idExQ.rd),
    .wen     (exValid && idExQ.ctrl.regWen),
    .wdata   (wbData),
    .rs1Data (rs1Raw),
    .rs2Data (rs2Raw)
  );

  // EX result bypasses the register file when ID reads the register EX writes
  assign fwdA = exValid && idExQ.ctrl.regWen && (idExQ.rd != 5'd0) && (idExQ.rd == rs1);
  assign fwdB = exValid && idExQ.ctrl.regWen && (idExQ.rd != 5'd0) && (idExQ.rd == rs2);

  assign idExIn.pc = ifIdQ.pc;
  assign idExIn.ctrl = ctrlId;
  assign idExIn.imm = immId;
  assign idExIn.rs1Data = fwdA ? wbData : rs1Raw;
  assign idExIn.rs2Data = fwdB ? wbData : rs2Raw;
  assign idExIn.rd = rdId;

  pipeStage #(.payloadT(rvCorePkg::idExT), .bubble(IdExBubble)) idExStage (
    .clk    (clk),
    .rst    (rst),
    .flush  (flush),
    .enable (!halted),
    .din    (idExIn),
    .dout   (idExQ)
  );

  // execute, memory access and write-back
  assign exValid = idExQ.ctrl.valid;
  assign opA = idExQ.ctrl.usePcA ? idExQ.pc : idExQ.rs1Data;
  assign opB = idExQ.ctrl.useImm ? idExQ.imm : idExQ.rs2Data;

  rvAlu alu0 (
    .opA    (opA),
    .opB    (opB),
    .aluOp  (idExQ.ctrl.aluOp),
    .result (aluResult)
  );

  loadStoreUnit lsu0 (
    .addr         (aluResult),
    .storeData    (idExQ.rs2Data),
    .rdataWord    (dataRdata),
    .memWidth     (idExQ.ctrl.memWidth),
    .loadUnsigned (idExQ.ctrl.loadUnsigned),
    .strb         (dataStrb),
    .wdataWord    (dataWdata),
    .loadData     (loadData)
  );

  assign dataAddr = {aluResult[`XLen-1:2], 2'b00};
  assign dataWen = exValid && idExQ.ctrl.memWen;
  assign dataRen = exValid && idExQ.ctrl.memRen;

  assign linkPc = idExQ.pc + InstBytes;
  assign wbData = idExQ.ctrl.isJump ? linkPc :
                  idExQ.ctrl.memRen ? loadData : aluResult;

  assign retireValid = exValid;
  assign retirePc = idExQ.pc;
  assign retireRd = idExQ.rd;
  assign retireData = (idExQ.ctrl.regWen && (idExQ.rd != 5'd0)) ? wbData : '0;

  // jalr drops bit 0 of the sum for the next pc
  assign taken = exValid && (idExQ.ctrl.isJump ||
                             (idExQ.ctrl.isBranch && aluResult[0]));
  assign transferTarget = idExQ.ctrl.isJalr ? {aluResult[`XLen-1:1], 1'b0} :
                                              (idExQ.pc + idExQ.imm);
  assign stopEx = exValid && (idExQ.ctrl.isEbreak || idExQ.ctrl.illegal);

  // the two younger slots die on a transfer or a halt
  assign flush = taken || stopEx;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `ResetPc;
    end else if (!halted && !stopEx) begin
      pc <= taken ? transferTarget : (pc + InstBytes);
    end
  end

  // marks a real instruction in ID since ifIdT has no valid bit
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      idValid <= 1'b0;
    end else if (!halted) begin
      idValid <= 1'b1;
    end
  end

  // only one stop can reach EX before everything freezes
  always_ff @(posedge clk) begin
    if (rst) begin
      halted <= 1'b0;
      trapIllegal <= 1'b0;
    end else if (stopEx) begin
      halted <= 1'b1;
      trapIllegal <= idExQ.ctrl.illegal;
    end
  end

endmodule

`default_nettype wire

/* bench/rvCore_assert.sv */
// Core protocol assertions
`timescale 1ns/1ps
`default_nettype none

module rvCoreAssert (
  input logic        clk,
  input logic        rst,
  input logic [31:0] instAddr,
  input logic [3:0]  dataStrb,
  input logic        dataWen,
  input logic        dataRen,
  input logic        retireValid,
  input logic        halted
);

  // one memory access per cycle at most
  assert property (@(posedge clk) disable iff (rst) !(dataWen && dataRen))
    else $error("data read and write in the same cycle");

  assert property (@(posedge clk) disable iff (rst) halted |-> !retireValid)
    else $error("retire seen while halted");

  assert property (@(posedge clk) disable iff (rst) dataWen |-> (dataStrb != 4'b0000))
    else $error("store with empty strobe");

  assert property (@(posedge clk) disable iff (rst) instAddr[1:0] == 2'b00)
    else $error("fetch address not word aligned");

endmodule

bind rvCore rvCoreAssert assert0 (
  .clk         (clk),
  .rst         (rst),
  .instAddr    (instAddr),
  .dataStrb    (dataStrb),
  .dataWen     (dataWen),
  .dataRen     (dataRen),
  .retireValid (retireValid),
  .halted      (halted)
);

`default_nettype wire

/* bench/rvCoreTb.sv */
// RV32I core testbench
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;

  logic clk;
  logic rst;
  logic [31:0] instAddr;
  logic [31:0] instData;
  logic [31:0] dataAddr;
  logic [31:0] dataWdata;
  logic [3:0] dataStrb;
  logic dataWen;
  logic dataRen;
  logic [31:0] dataRdata;
  logic retireValid;
  logic [31:0] retirePc;
  logic [4:0] retireRd;
  logic [31:0] retireData;
  logic halted;
  logic trapIllegal;

  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  logic [31:0] expPc [$];
  logic [31:0] expRd [$];
  logic [31:0] expData [$];
  logic [31:0] stAddr [$];
  logic [31:0] stStrb [$];
  logic [31:0] stData [$];
  logic [31:0] trapAddr [$];
  logic [31:0] trapWord [$];
  int rIdx;
  int sIdx;
  logic checkOn;
  logic pendWen;
  logic [31:0] pendAddr;
  logic [31:0] pendData;
  logic [3:0] pendStrb;
  logic expRen;
  logic [31:0] lastRetirePc;

  rvCore dut0 (
    .clk         (clk),
    .rst         (rst),
    .instAddr    (instAddr),
    .instData    (instData),
    .dataAddr    (dataAddr),
    .dataWdata   (dataWdata),
    .dataStrb    (dataStrb),
    .dataWen     (dataWen),
    .dataRen     (dataRen),
    .dataRdata   (dataRdata),
    .retireValid (retireValid),
    .retirePc    (retirePc),
    .retireRd    (retireRd),
    .retireData  (retireData),
    .halted      (halted),
    .trapIllegal (trapIllegal)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // same-cycle memories
  assign instData = imem[instAddr[9:2]];
  assign dataRdata = dmem[dataAddr[9:2]];

  task automatic failNow(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fillMemories();
    for (int i = 0; i < 256; i++) begin
      // addi x31, x0, i as filler code
      imem[i] = 32'h00000f93 | (i << 20);
      dmem[i] = 32'ha5000000 ^ (i * 32'h00010101);
    end
  endtask

  task automatic loadStim();
    int fd;
    int code;
    string tag;
    string line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    fd = $fopen("bench/rvCore_stim.txt", "r");
    if (fd == 0) begin
      failNow("could not open the stim file");
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        break;
      end
      if (tag == "#") begin
        code = $fgets(line, fd);
      end else if (tag == "I" || tag == "D" || tag == "X") begin
        code = $fscanf(fd, "%h %h", a, b);
        if (code != 2) begin
          failNow("a stim line has too few fields");
        end
        if (tag == "I") imem[a[9:2]] = b;
        else if (tag == "D") dmem[a[9:2]] = b;
        else begin
          trapAddr.push_back(a);
          trapWord.push_back(b);
        end
      end else if (tag == "R" || tag == "S") begin
        code = $fscanf(fd, "%h %h %h", a, b, c);
        if (code != 3) begin
          failNow("a stim line has too few fields");
        end
        if (tag == "R") begin
          expPc.push_back(a);
          expRd.push_back(b);
          expData.push_back(c);
        end else begin
          stAddr.push_back(a);
          stStrb.push_back(b);
          stData.push_back(c);
        end
      end else begin
        failNow("unknown tag in the stim file");
      end
    end
    $fclose(fd);
  endtask

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    pendWen <= 1'b0;
    if (!rst && checkOn) begin
      if (retireValid) begin
        if (rIdx >= expPc.size()) begin
          failNow("the core retired more instructions than expected");
        end
        checkValue("retirePc", expPc[rIdx], retirePc);
        checkValue("retireRd", expRd[rIdx], {27'd0, retireRd});
        checkValue("retireData", expData[rIdx], retireData);
        rIdx++;
      end
      // only a load in EX reads data memory
      expRen = retireValid && (imem[retirePc[9:2]][6:0] == 7'b0000011);
      checkValue("dataRen", {31'd0, expRen}, {31'd0, dataRen});
      if (dataWen) begin
        if (sIdx >= stAddr.size()) begin
          failNow("the core stored more often than expected");
        end
        checkValue("storeAddr", stAddr[sIdx], dataAddr);
        checkValue("storeStrb", stStrb[sIdx], {28'd0, dataStrb});
        checkValue("storeData", stData[sIdx], dataWdata);
        sIdx++;
      end
    end
    if (!rst && retireValid) begin
      lastRetirePc <= retirePc;
    end
    if (!rst && dataWen) begin
      pendWen <= 1'b1;
      pendAddr <= dataAddr;
      pendData <= dataWdata;
      pendStrb <= dataStrb;
    end
  end

  // store lands at the edge closing its cycle
  always @(posedge clk) begin
    if (pendWen) begin
      for (int b = 0; b < 4; b++) begin
        if (pendStrb[b]) begin
          dmem[pendAddr[9:2]][b*8 +: 8] <= pendData[b*8 +: 8];
        end
      end
    end
  end

  task automatic applyReset();
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
  endtask

  task automatic waitHalt();
    int cycles;
    cycles = 0;
    while (!halted) begin
      @(negedge clk);
      cycles++;
      if (cycles > 2000) begin
        failNow("the core never halted");
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    checkOn = 1'b1;
    pendWen = 1'b0;
    rIdx = 0;
    sIdx = 0;
    fillMemories();
    loadStim();
    applyReset();
    // the first retire sits at the reset pc
    checkValue("instAddrAfterReset", expPc[0], instAddr);
    waitHalt();
    // nothing may retire or store after the halt
    repeat (5) @(posedge clk);
    checkValue("retireCount", expPc.size(), rIdx);
    checkValue("storeCount", stAddr.size(), sIdx);
    checkValue("trapAfterEbreak", 32'd0, {31'd0, trapIllegal});

    // second program ends on an illegal word
    checkOn = 1'b0;
    @(posedge clk);
    #1 rst = 1'b1;
    for (int i = 0; i < trapAddr.size(); i++) begin
      imem[trapAddr[i][9:2]] = trapWord[i];
    end
    applyReset();
    waitHalt();
    @(posedge clk);
    checkValue("trapIllegal", 32'd1, {31'd0, trapIllegal});
    // the illegal word is the last one that may retire
    checkValue("trapPc", trapAddr[trapAddr.size() - 1], lastRetirePc);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* rvCore.f */
+incdir+verilog
verilog/rvCorePkg.sv
verilog/pipeStage.sv
verilog/rvDecoder.sv
verilog/regFile.sv
verilog/rvAlu.sv
verilog/loadStoreUnit.sv
verilog/rvCore.sv
bench/rvCore_assert.sv
bench/rvCoreTb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wall -f rvCore.f --top-module rvCoreTb -o simv
	./obj_dir/simv | tee sim.log
	grep -qF "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/rvCore_stim.txt */
# I/X addr word = program (X is the illegal-trap program), D addr word = data
# R pc rd value = expected retire, S addr strb data = expected store, all hex
I 0 80000137
I 4 FFD00093
I 8 41F15193
I C 00115233
I 10 0000A2B3
I 14 00103333
I 18 006283B3
I 1C 40138433
I 20 00001497
I 24 0F044513
I 28 10000593
I 2C 0015A023
I 30 00A582A3
I 34 00A59323
I 38 00558603
I 3C 0055C683
I 40 00459703
I 44 0045D783
I 48 0005A803
I 4C 00180893
I 50 01088463
I 54 01089663
I 60 0000C463
I 68 00107463
I 6C 00C0096F
I 78 08500993
I 7C 00098A67
I 84 00700013
I 88 00000AB3
I 8C 00105463
I 94 0000E463
I 98 00100073
D 100 00000000
D 104 11223344
R 0 2 80000000
R 4 1 FFFFFFFD
R 8 3 FFFFFFFF
R C 4 4
R 10 5 1
R 14 6 1
R 18 7 2
R 1C 8 5
R 20 9 1020
R 24 A F5
R 28 B 100
R 2C 0 0
R 30 0 0
R 34 0 0
R 38 C FFFFFFF5
R 3C D F5
R 40 E FFFFF544
R 44 F F544
R 48 10 FFFFFFFD
R 4C 11 FFFFFFFE
R 50 0 0
R 54 0 0
R 60 0 0
R 68 0 0
R 6C 12 70
R 78 13 85
R 7C 14 80
R 84 0 0
R 88 15 0
R 8C 0 0
R 94 0 0
R 98 0 0
S 100 F FFFFFFFD
S 104 2 F5F5F5F5
S 104 C 00F500F5
X 0 00100093
X 4 FFFFFFFF
